/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/dmem_if.sv
      - verilog/memory_stage.sv
      - verilog/lane_splitter.sv
      - verilog/byte_bank.sv
      - verilog/lane_merger.sv
      - verilog/mem_subsystem.sv
  - target: test
    files:
      - bench/tb_mem_subsystem.sv

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
	import mem_pkg::*;

	localparam time CLK_PERIOD = 100ns;
	localparam int NUM_OPS = 700; // Upper bound on driven operations.
	localparam int OP_TIMEOUT = 16;
	localparam int MODEL_AW = BANK_ADDR_W + OFFSET_W;

	logic clk = 1'b0;
	logic arst_n;
	logic [XLEN-1:0] reg_pc;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_out;
	mem_op_t mem_op;
	logic [WB_SEL_W-1:0] wb_sel;
	logic [XLEN-1:0] read_data;
	logic [XLEN-1:0] out_reg_pc;
	logic [XLEN-1:0] out_alu_out;
	logic [WB_SEL_W-1:0] out_wb_sel;
	logic next_flg;
	logic stall;

	logic [BYTE_W-1:0] model [1 << MODEL_AW];
	logic [XLEN-1:0] exp_rd, exp_pc, exp_alu;
	logic [WB_SEL_W-1:0] exp_wb;
	logic [XLEN-1:0] chk_rd, chk_pc, chk_alu;
	logic [WB_SEL_W-1:0] chk_wb;
	integer seed;
	int error_count;
	int check_count;

	mem_subsystem mem_subsystem_inst (
		.clk(clk),
		.arst_n(arst_n),
		.reg_pc(reg_pc),
		.rs2_data(rs2_data),
		.alu_out(alu_out),
		.mem_op(mem_op),
		.wb_sel(wb_sel),
		.read_data(read_data),
		.out_reg_pc(out_reg_pc),
		.out_alu_out(out_alu_out),
		.out_wb_sel(out_wb_sel),
		.next_flg(next_flg),
		.stall(stall)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [XLEN-1:0] actual,
			input logic [XLEN-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name,
				actual, expected);
		end
	endtask

	// Little endian, truncated to the access size.
	function automatic logic [XLEN-1:0] load_ref(input mem_op_t op, input logic [XLEN-1:0] addr);
		logic [MODEL_AW-1:0] a;
		logic [7:0] b;
		logic [15:0] h;
		logic [31:0] w;
		a = addr[MODEL_AW-1:0];
		b = model[a];
		h = {model[{a[MODEL_AW-1:1], 1'b1}], model[{a[MODEL_AW-1:1], 1'b0}]};
		w = {model[{a[MODEL_AW-1:2], 2'd3}], model[{a[MODEL_AW-1:2], 2'd2}],
			model[{a[MODEL_AW-1:2], 2'd1}], model[{a[MODEL_AW-1:2], 2'd0}]};
		case (op)
			MEM_LB: return {{24{b[7]}}, b};
			MEM_LBU: return {24'h0, b};
			MEM_LH: return {{16{h[15]}}, h};
			MEM_LHU: return {16'h0, h};
			MEM_LW: return w;
			default: return '1; // Stores and idle.
		endcase
	endfunction

	task automatic store_model(input mem_op_t op, input logic [XLEN-1:0] addr,
			input logic [XLEN-1:0] data);
		logic [MODEL_AW-1:0] a;
		a = addr[MODEL_AW-1:0];
		case (op)
			MEM_SB: model[a] = data[7:0];
			MEM_SH: begin
				model[{a[MODEL_AW-1:1], 1'b0}] = data[7:0];
				model[{a[MODEL_AW-1:1], 1'b1}] = data[15:8];
			end
			MEM_SW: begin
				for (int i = 0; i < NUM_LANES; i++) begin
					model[{a[MODEL_AW-1:2], 2'(i)}] = data[i*8 +: 8];
				end
			end
			default: ;
		endcase
	endtask

	// Drive at a falling edge, return at the falling edge after completion.
	task automatic run_op(input mem_op_t op, input logic [XLEN-1:0] addr,
			input logic [XLEN-1:0] data, input logic [XLEN-1:0] pc,
			input logic [WB_SEL_W-1:0] wb);
		int waited;
		waited = 0;
		mem_op = op;
		alu_out = addr;
		rs2_data = data;
		reg_pc = pc;
		wb_sel = wb;
		exp_rd = load_ref(op, addr);
		exp_pc = pc;
		exp_alu = addr;
		exp_wb = wb;
		store_model(op, addr, data);
		#1;
		if (op == MEM_NONE) begin
			check_value("next_flg", next_flg, 1'b1); // Idle completes at once.
		end
		while (!next_flg && waited < OP_TIMEOUT) begin
			check_value("stall", stall, 1'b1);
			@(negedge clk);
			waited++;
		end
		if (waited == OP_TIMEOUT) begin
			error_count++;
			$display("Operation %s at %h did not finish within %0d cycles", op.name(), addr,
				OP_TIMEOUT);
		end else begin
			check_value("stall", stall, 1'b0);
		end
		@(negedge clk);
	endtask

	// Outputs registered at an edge that saw next_flg high.
	always @(posedge clk) begin
		if (arst_n && next_flg) begin
			chk_rd = exp_rd;
			chk_pc = exp_pc;
			chk_alu = exp_alu;
			chk_wb = exp_wb;
			@(negedge clk);
			check_value("read_data", read_data, chk_rd);
			check_value("out_reg_pc", out_reg_pc, chk_pc);
			check_value("out_alu_out", out_alu_out, chk_alu);
			check_value("out_wb_sel", out_wb_sel, chk_wb);
		end
	end

	initial begin
		#(NUM_OPS * 8 * CLK_PERIOD + 100 * CLK_PERIOD);
		$display("Test hung: watchdog expired before the operations completed");
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		mem_op_t op;
		logic [XLEN-1:0] r_addr, r_data, r_pc;
		logic [WB_SEL_W-1:0] r_wb;
		seed = 32'h84ac_0fad;
		error_count = 0;
		check_count = 0;
		arst_n = 1'b0;
		mem_op = MEM_NONE;
		reg_pc = '0;
		rs2_data = '0;
		alu_out = '0;
		wb_sel = '0;
		exp_rd = '1;
		exp_pc = '0;
		exp_alu = '0;
		exp_wb = '0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;

		run_op(MEM_NONE, 32'h0000_0123, 32'hdead_beef, 32'h0000_1000, 4'h5);

		// Fill pattern from the word index.
		for (int i = 0; i < (1 << BANK_ADDR_W); i++) begin
			r_data = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
			run_op(MEM_SW, XLEN'(i * 4), r_data, 32'h0000_2000 + XLEN'(i * 4), 4'h1);
		end

		for (int i = 0; i < 4; i++) begin
			r_addr = XLEN'(i * 12'h0f4 + 4);
			run_op(MEM_SW, r_addr, 32'hc0de_0000 | XLEN'(i * 32'h1111), 32'h3000, 4'h2);
			run_op(MEM_LW, r_addr, 32'h0, 32'h3004, 4'h3);
		end

		// Bytes with the sign bit set and clear.
		run_op(MEM_SB, 32'h40, 32'hffff_ff81, 32'h4000, 4'h4);
		run_op(MEM_SB, 32'h41, 32'h0000_007f, 32'h4004, 4'h4);
		run_op(MEM_SB, 32'h42, 32'h1234_56c3, 32'h4008, 4'h4);
		run_op(MEM_SB, 32'h43, 32'h0000_0012, 32'h400c, 4'h4);
		for (int i = 0; i < 4; i++) begin
			run_op(MEM_LB, XLEN'(32'h40 + i), 32'h0, 32'h4010, 4'h6);
			run_op(MEM_LBU, XLEN'(32'h40 + i), 32'h0, 32'h4014, 4'h7);
		end
		run_op(MEM_SB, 32'h45, 32'h0000_00a5, 32'h4018, 4'h4);
		run_op(MEM_LW, 32'h44, 32'h0, 32'h401c, 4'h8);

		run_op(MEM_SH, 32'h80, 32'hffff_8001, 32'h5000, 4'h9);
		run_op(MEM_SH, 32'h82, 32'h0000_7ffe, 32'h5004, 4'h9);
		run_op(MEM_LH, 32'h80, 32'h0, 32'h5008, 4'ha);
		run_op(MEM_LHU, 32'h80, 32'h0, 32'h500c, 4'hb);
		run_op(MEM_LH, 32'h82, 32'h0, 32'h5010, 4'ha);
		run_op(MEM_LHU, 32'h82, 32'h0, 32'h5014, 4'hb);
		run_op(MEM_SH, 32'h85, 32'h0000_beef, 32'h5018, 4'h9); // Lands at 0x84.
		run_op(MEM_LH, 32'h85, 32'h0, 32'h501c, 4'hc);
		run_op(MEM_LHU, 32'h87, 32'h0, 32'h5020, 4'hd);

		for (int n = 0; n < 200; n++) begin
			op = mem_op_t'($unsigned($random(seed)) % 8 + 1);
			r_addr = $random(seed) & 32'h3ff;
			r_data = $random(seed);
			r_pc = $random(seed);
			r_wb = WB_SEL_W'($random(seed));
			run_op(op, r_addr, r_data, r_pc, r_wb);
			if ($random(seed) & 1) begin
				r_pc = $random(seed);
				run_op(MEM_NONE, $random(seed), $random(seed), r_pc, 4'hf);
			end
		end
		run_op(MEM_NONE, 32'h0, 32'h0, 32'h0, 4'h0);
		@(posedge clk); // Last compare done at the falling edge.

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* list.f */
verilog/mem_pkg.sv
verilog/dmem_if.sv
verilog/memory_stage.sv
verilog/lane_splitter.sv
verilog/byte_bank.sv
verilog/lane_merger.sv
verilog/mem_subsystem.sv
bench/tb_mem_subsystem.sv

/* verilog/byte_bank.sv */
`timescale 1ns/1ps

module byte_bank (
	input logic clk,
	input logic [mem_pkg::BANK_ADDR_W-1:0] index,
	input logic we,
	input logic [mem_pkg::BYTE_W-1:0] wbyte,
	output logic [mem_pkg::BYTE_W-1:0] rbyte
);
	import mem_pkg::*;

	logic [BYTE_W-1:0] mem [BANK_DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wbyte;
		end
		rbyte <= mem[index]; // Old data on a same-cycle write.
	end

endmodule

/* verilog/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if;
	import mem_pkg::*;

	mem_cmd_t cmd;
	logic [XLEN-1:0] addr;
	mem_size_t size;
	logic [XLEN-1:0] wdata; // Store data in the low bits.
	logic ready;
	logic [XLEN-1:0] rdata;
	logic rdata_valid;

	modport stage (
		output cmd, addr, size, wdata,
		input ready, rdata, rdata_valid
	);

	modport memory (
		input cmd, addr, size, wdata,
		output ready, rdata, rdata_valid
	);

endinterface

/* verilog/lane_merger.sv */
`timescale 1ns/1ps

module lane_merger (
	input logic clk,
	input logic arst_n,
	input logic [mem_pkg::BYTE_W-1:0] bank_rbyte [mem_pkg::NUM_LANES],
	input logic rd_pend,
	input logic [mem_pkg::OFFSET_W-1:0] rd_offset,
	dmem_if.memory dmem
);
	import mem_pkg::*;

	logic pend_q;
	logic [OFFSET_W-1:0] offset_q;
	logic [$clog2(XLEN)-1:0] shamt;
	logic [XLEN-1:0] word;
	logic [XLEN-1:0] rotated;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			word[i*BYTE_W +: BYTE_W] = bank_rbyte[i];
		end
	end

	// Addressed byte or half down to bit 0.
	assign shamt = {offset_q, 3'b000};
	assign rotated = (word >> shamt) | (word << (XLEN - shamt));

	always_ff @(posedge clk) begin
		if (rd_pend) begin
			offset_q <= rd_offset;
		end
		if (pend_q) begin
			dmem.rdata <= rotated;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_q <= 1'b0;
			dmem.rdata_valid <= 1'b0;
		end else begin
			pend_q <= rd_pend; // Aligned with bank output.
			dmem.rdata_valid <= pend_q;
		end
	end

endmodule

/* verilog/lane_splitter.sv */
`timescale 1ns/1ps

module lane_splitter (
	input logic clk,
	input logic arst_n,
	dmem_if.memory dmem,
	output logic [mem_pkg::BANK_ADDR_W-1:0] bank_index [mem_pkg::NUM_LANES],
	output logic [mem_pkg::NUM_LANES-1:0] bank_we,
	output logic [mem_pkg::BYTE_W-1:0] bank_wbyte [mem_pkg::NUM_LANES],
	output logic rd_pend,
	output logic [mem_pkg::OFFSET_W-1:0] rd_offset
);
	import mem_pkg::*;

	logic [BANK_ADDR_W-1:0] word_index;
	logic [OFFSET_W-1:0] offset;
	logic [NUM_LANES-1:0] strobe;
	logic [$clog2(XLEN)-1:0] shamt;
	logic [XLEN-1:0] lane_data;
	logic [BUSY_CNT_W-1:0] busy_cnt;

	// Addresses above 1 KiB alias.
	assign word_index = dmem.addr[OFFSET_W +: BANK_ADDR_W];

	always_comb begin
		case (dmem.size)
			SIZE_BYTE: begin
				offset = dmem.addr[OFFSET_W-1:0];
				strobe = NUM_LANES'(1) << offset;
			end
			SIZE_HALF: begin
				offset = {dmem.addr[1], 1'b0}; // Bit 0 dropped.
				strobe = NUM_LANES'(3) << offset;
			end
			default: begin
				offset = '0;
				strobe = '1;
			end
		endcase
	end

	// Rotate store bytes up into their lanes.
	assign shamt = {offset, 3'b000};
	assign lane_data = (dmem.wdata << shamt) | (dmem.wdata >> (XLEN - shamt));

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			bank_index[i] = word_index;
			bank_wbyte[i] = lane_data[i*BYTE_W +: BYTE_W];
			bank_we[i] = dmem.cmd == CMD_WRITE && strobe[i];
		end
	end

	assign rd_pend = dmem.cmd == CMD_READ;
	assign rd_offset = offset;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_cnt <= '0;
		end else if (rd_pend) begin
			busy_cnt <= BUSY_CNT_W'(READ_BUSY_CYCLES);
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	assign dmem.ready = busy_cnt == '0;

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

	localparam int XLEN = 32;
	localparam int BYTE_W = 8;
	localparam int WB_SEL_W = 4;

	// Four byte banks of 256 entries, 1 KiB in all.
	localparam int NUM_LANES = 4;
	localparam int OFFSET_W = $clog2(NUM_LANES);
	localparam int BANK_ADDR_W = 8;
	localparam int BANK_DEPTH = 1 << BANK_ADDR_W;

	localparam int READ_BUSY_CYCLES = 2; // Ready low after a read.
	localparam int BUSY_CNT_W = $clog2(READ_BUSY_CYCLES + 1);

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LBU,
		MEM_LH,
		MEM_LHU,
		MEM_LW,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_t;

	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_READ,
		CMD_WRITE
	} mem_cmd_t;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} mem_size_t;

endpackage

/* verilog/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
	input logic clk,
	input logic arst_n,
	input logic [mem_pkg::XLEN-1:0] reg_pc,
	input logic [mem_pkg::XLEN-1:0] rs2_data,
	input logic [mem_pkg::XLEN-1:0] alu_out,
	input mem_pkg::mem_op_t mem_op,
	input logic [mem_pkg::WB_SEL_W-1:0] wb_sel,
	output logic [mem_pkg::XLEN-1:0] read_data,
	output logic [mem_pkg::XLEN-1:0] out_reg_pc,
	output logic [mem_pkg::XLEN-1:0] out_alu_out,
	output logic [mem_pkg::WB_SEL_W-1:0] out_wb_sel,
	output logic next_flg,
	output logic stall
);
	import mem_pkg::*;

	dmem_if dmem ();

	logic [BANK_ADDR_W-1:0] bank_index [NUM_LANES];
	logic [NUM_LANES-1:0] bank_we;
	logic [BYTE_W-1:0] bank_wbyte [NUM_LANES];
	logic [BYTE_W-1:0] bank_rbyte [NUM_LANES];
	logic rd_pend;
	logic [OFFSET_W-1:0] rd_offset;

	memory_stage memory_stage_inst (
		.clk(clk),
		.arst_n(arst_n),
		.reg_pc(reg_pc),
		.rs2_data(rs2_data),
		.alu_out(alu_out),
		.mem_op(mem_op),
		.wb_sel(wb_sel),
		.read_data(read_data),
		.out_reg_pc(out_reg_pc),
		.out_alu_out(out_alu_out),
		.out_wb_sel(out_wb_sel),
		.next_flg(next_flg),
		.stall(stall),
		.dmem(dmem.stage)
	);

	lane_splitter lane_splitter_inst (
		.clk(clk),
		.arst_n(arst_n),
		.dmem(dmem.memory),
		.bank_index(bank_index),
		.bank_we(bank_we),
		.bank_wbyte(bank_wbyte),
		.rd_pend(rd_pend),
		.rd_offset(rd_offset)
	);

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_bank
		byte_bank byte_bank_inst (
			.clk(clk),
			.index(bank_index[lane]),
			.we(bank_we[lane]),
			.wbyte(bank_wbyte[lane]),
			.rbyte(bank_rbyte[lane])
		);
	end

	lane_merger lane_merger_inst (
		.clk(clk),
		.arst_n(arst_n),
		.bank_rbyte(bank_rbyte),
		.rd_pend(rd_pend),
		.rd_offset(rd_offset),
		.dmem(dmem.memory)
	);

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
	input logic clk,
	input logic arst_n,
	input logic [mem_pkg::XLEN-1:0] reg_pc,
	input logic [mem_pkg::XLEN-1:0] rs2_data,
	input logic [mem_pkg::XLEN-1:0] alu_out,
	input mem_pkg::mem_op_t mem_op,
	input logic [mem_pkg::WB_SEL_W-1:0] wb_sel,
	output logic [mem_pkg::XLEN-1:0] read_data,
	output logic [mem_pkg::XLEN-1:0] out_reg_pc,
	output logic [mem_pkg::XLEN-1:0] out_alu_out,
	output logic [mem_pkg::WB_SEL_W-1:0] out_wb_sel,
	output logic next_flg,
	output logic stall,
	dmem_if.stage dmem
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_WAIT_READY,
		ST_WAIT_READ_VAL,
		ST_END
	} state_t;

	state_t state;

	logic [XLEN-1:0] save_pc;
	logic [XLEN-1:0] save_alu;
	logic [XLEN-1:0] save_rs2;
	mem_op_t save_op;
	logic [WB_SEL_W-1:0] save_wb_sel;

	logic is_store;
	logic [XLEN-1:0] load_ext;

	assign is_store = save_op inside {MEM_SB, MEM_SH, MEM_SW};

	assign next_flg = (state == ST_WAIT && mem_op == MEM_NONE) || state == ST_END;
	assign stall = !next_flg;

	// Command only while waiting and the memory is ready.
	assign dmem.cmd = (state == ST_WAIT_READY && dmem.ready) ?
		(is_store ? CMD_WRITE : CMD_READ) : CMD_NONE;
	assign dmem.addr = save_alu;
	assign dmem.wdata = save_rs2;

	always_comb begin
		case (save_op)
			MEM_LB, MEM_LBU, MEM_SB: dmem.size = SIZE_BYTE;
			MEM_LH, MEM_LHU, MEM_SH: dmem.size = SIZE_HALF;
			default: dmem.size = SIZE_WORD;
		endcase
	end

	always_comb begin
		case (save_op)
			MEM_LB: load_ext = {{(XLEN-8){dmem.rdata[7]}}, dmem.rdata[7:0]};
			MEM_LBU: load_ext = {{(XLEN-8){1'b0}}, dmem.rdata[7:0]};
			MEM_LH: load_ext = {{(XLEN-16){dmem.rdata[15]}}, dmem.rdata[15:0]};
			MEM_LHU: load_ext = {{(XLEN-16){1'b0}}, dmem.rdata[15:0]};
			default: load_ext = dmem.rdata;
		endcase
	end

	// Instruction fields held for the whole access.
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && mem_op != MEM_NONE) begin
			save_pc <= reg_pc;
			save_alu <= alu_out;
			save_rs2 <= rs2_data;
			save_op <= mem_op;
			save_wb_sel <= wb_sel;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_WAIT;
			read_data <= '1;
			out_reg_pc <= '0;
			out_alu_out <= '0;
			out_wb_sel <= '0;
		end else begin
			case (state)
				ST_WAIT: begin
					if (mem_op != MEM_NONE) begin
						state <= ST_WAIT_READY;
					end else begin
						read_data <= '1; // Pass-through.
						out_reg_pc <= reg_pc;
						out_alu_out <= alu_out;
						out_wb_sel <= wb_sel;
					end
				end
				ST_WAIT_READY: begin
					if (dmem.ready) begin
						if (is_store) begin
							read_data <= '1;
							state <= ST_END;
						end else begin
							state <= ST_WAIT_READ_VAL;
						end
					end
				end
				ST_WAIT_READ_VAL: begin
					if (dmem.rdata_valid) begin
						read_data <= load_ext;
						state <= ST_END;
					end
				end
				default: begin
					out_reg_pc <= save_pc;
					out_alu_out <= save_alu;
					out_wb_sel <= save_wb_sel;
					state <= ST_WAIT;
				end
			endcase
		end
	end

endmodule
